/* logic/map_table.sv */
`timescale 1ns/1ns
// register-to-tag map table of the two-wide rename stage
// looks up source producers, forwards slot 1's destination to slot 2,
// records new producers and marks entries ready from the data buses
module map_table (
   input  logic               clock,
   input  logic               reset,
   input  logic               flush,
   input  rename_pkg::tag_t   cdb1_tag,
   input  rename_pkg::tag_t   cdb2_tag,
   rename_slot_if.map         slot1,
   rename_slot_if.map         slot2
);
   import rename_pkg::*;

   // one entry per architectural register
   localparam int NUM_REGS = 2 ** $bits(reg_idx_t);

   ////////////////////////////////////////
   // table storage
   ////////////////////////////////////////

   tag_t tag_table [NUM_REGS];
   tag_t next_table [NUM_REGS];

   // a slot writes only with a real destination and a granted tag
   logic slot1_writes;
   logic slot2_writes;

   // slot 2 source matches slot 1's destination
   logic fwd_a;
   logic fwd_b;

   assign slot1_writes = (slot1.dest != ZERO_REG) && (slot1.tag != TAG_NULL);
   assign slot2_writes = (slot2.dest != ZERO_REG) && (slot2.tag != TAG_NULL);

   ////////////////////////////////////////
   // source lookup
   ////////////////////////////////////////

   // slot 1 sees the table as it stood before this cycle
   assign slot1.taga = reset ? TAG_NULL : tag_table[slot1.rega];
   assign slot1.tagb = reset ? TAG_NULL : tag_table[slot1.regb];

   // slot 2 is younger, so slot 1's new producer hides the table entry
   assign fwd_a = slot1_writes && (slot2.rega == slot1.dest);
   assign fwd_b = slot1_writes && (slot2.regb == slot1.dest);

   assign slot2.taga = reset ? TAG_NULL
                     : fwd_a ? slot1.tag
                     : tag_table[slot2.rega];
   assign slot2.tagb = reset ? TAG_NULL
                     : fwd_b ? slot1.tag
                     : tag_table[slot2.regb];

   ////////////////////////////////////////
   // next-state rules
   ////////////////////////////////////////

   always_comb
   begin
      logic cdb_hit;
      logic ready;
      for (int i = 0; i < NUM_REGS; i++)
      begin
         // only a live tag can match, the null tag never broadcasts
         cdb_hit = ((cdb1_tag == tag_table[i]) && (cdb1_tag != TAG_NULL))
                || ((cdb2_tag == tag_table[i]) && (cdb2_tag != TAG_NULL));
         // once ready the bit stays set until the entry is rewritten
         ready = tag_table[i][6] || cdb_hit;

         // slot 2 wins a double write since it comes later in order
         if (slot2_writes && (slot2.dest == reg_idx_t'(i)))
         begin
            next_table[i] = slot2.tag;
         end
         else if (slot1_writes && (slot1.dest == reg_idx_t'(i)))
         begin
            next_table[i] = slot1.tag;
         end
         else if (flush || (tag_table[i] == TAG_NULL))
         begin
            next_table[i] = TAG_NULL;
         end
         else
         begin
            // keep the rob index, refresh the ready flag
            next_table[i] = {1'b0, ready, tag_table[i][5:0]};
         end
      end
      // zero register never holds a producer
      next_table[ZERO_REG] = TAG_NULL;
   end

   ////////////////////////////////////////
   // table update
   ////////////////////////////////////////

   always_ff @(posedge clock)
   begin
      // every register starts out committed
      if (reset)
      begin
         for (int i = 0; i < NUM_REGS; i++)
         begin
            tag_table[i] <= TAG_NULL;
         end
      end
      else
      begin
         for (int i = 0; i < NUM_REGS; i++)
         begin
            tag_table[i] <= next_table[i];
         end
      end
   end

endmodule

/* logic/rename_pkg.sv */
// shared types and constants for the two-wide register rename stage
// imported by the allocator, the map table and the slot interface
package rename_pkg;

   ////////////////////////////////////////
   // register and tag types
   ////////////////////////////////////////

   // architectural register number, 32 registers
   typedef logic [4:0] reg_idx_t;

   // reorder-buffer tag
   // bit 7 set only in the null tag
   // bit 6 is the ready flag, set once a data bus broadcasts the tag
   // bits 5..0 hold the reorder-buffer index
   typedef logic [7:0] tag_t;

   // width of the index field inside a tag
   localparam int TAG_INDEX_BITS = 6;

   ////////////////////////////////////////
   // special values
   ////////////////////////////////////////

   // no producer in flight, register holds its committed value
   localparam tag_t TAG_NULL = 8'hff;

   // hard-wired zero register, never renamed
   localparam reg_idx_t ZERO_REG = 5'd31;

endpackage

/* logic/rename_slot_if.sv */
`timescale 1ns/1ns
// one instruction slot of the rename stage
// carries the slot's request from the top and the tags it gets back
// from the allocator and the map table
interface rename_slot_if;
   import rename_pkg::*;

   // request side, driven by the top
   logic     valid;
   reg_idx_t rega;
   reg_idx_t regb;
   reg_idx_t dest;

   // allocated destination tag, TAG_NULL when no tag is granted
   tag_t     tag;

   // producer tags of the two sources
   tag_t     taga;
   tag_t     tagb;

   // allocator sees only the request and returns the new tag
   modport alloc (input valid, output tag);

   // map table reads registers and the new tag, returns source tags
   modport map (input rega, input regb, input dest, input tag,
                output taga, output tagb);

   // top drives requests and collects every result
   modport top (output valid, output rega, output regb, output dest,
                input tag, input taga, input tagb);

endinterface

/* logic/rename_unit.sv */
`timescale 1ns/1ns
// top level of the two-wide register rename stage
// takes two instruction slots per cycle and returns destination tags,
// source producer tags and a stall for the whole stage
module rename_unit #(
   parameter int ROB_DEPTH = 32
) (
   input  logic                 clock,
   input  logic                 reset,
   input  logic                 flush,
   // tags freed by retirement, 0 to 2 per cycle
   input  logic [1:0]           retire_count,
   // common data bus broadcasts
   input  rename_pkg::tag_t     cdb1_tag,
   input  rename_pkg::tag_t     cdb2_tag,

   // slot 1, the older instruction
   input  logic                 inst1_valid,
   input  rename_pkg::reg_idx_t inst1_rega,
   input  rename_pkg::reg_idx_t inst1_regb,
   input  rename_pkg::reg_idx_t inst1_dest,

   // slot 2, the younger instruction
   input  logic                 inst2_valid,
   input  rename_pkg::reg_idx_t inst2_rega,
   input  rename_pkg::reg_idx_t inst2_regb,
   input  rename_pkg::reg_idx_t inst2_dest,

   // stage stalls when the rob cannot take all valid slots
   output logic                 stall,

   // results of slot 1
   output rename_pkg::tag_t     inst1_tag,
   output rename_pkg::tag_t     inst1_taga,
   output rename_pkg::tag_t     inst1_tagb,

   // results of slot 2
   output rename_pkg::tag_t     inst2_tag,
   output rename_pkg::tag_t     inst2_taga,
   output rename_pkg::tag_t     inst2_tagb
);

   ////////////////////////////////////////
   // slot bundles
   ////////////////////////////////////////

   rename_slot_if slot1 ();
   rename_slot_if slot2 ();

   // requests in
   assign slot1.valid = inst1_valid;
   assign slot1.rega  = inst1_rega;
   assign slot1.regb  = inst1_regb;
   assign slot1.dest  = inst1_dest;

   assign slot2.valid = inst2_valid;
   assign slot2.rega  = inst2_rega;
   assign slot2.regb  = inst2_regb;
   assign slot2.dest  = inst2_dest;

   // results out
   assign inst1_tag  = slot1.tag;
   assign inst1_taga = slot1.taga;
   assign inst1_tagb = slot1.tagb;

   assign inst2_tag  = slot2.tag;
   assign inst2_taga = slot2.taga;
   assign inst2_tagb = slot2.tagb;

   ////////////////////////////////////////
   // allocator and map table
   ////////////////////////////////////////

   // rob tags come first, the table records them in the same cycle
   tag_alloc #(
      .ROB_DEPTH    (ROB_DEPTH)
   ) u_tag_alloc (
      .clock        (clock),
      .reset        (reset),
      .flush        (flush),
      .retire_count (retire_count),
      .slot1        (slot1.alloc),
      .slot2        (slot2.alloc),
      .stall        (stall)
   );

   map_table u_map_table (
      .clock        (clock),
      .reset        (reset),
      .flush        (flush),
      .cdb1_tag     (cdb1_tag),
      .cdb2_tag     (cdb2_tag),
      .slot1        (slot1.map),
      .slot2        (slot2.map)
   );

endmodule

/* logic/tag_alloc.sv */
`timescale 1ns/1ns
// circular reorder-buffer tag allocator for the two-wide rename stage
// grants zero, one or two consecutive tags per cycle and raises stall
// when the free count cannot cover the valid slots
module tag_alloc #(
   parameter int ROB_DEPTH = 32
) (
   input  logic         clock,
   input  logic         reset,
   input  logic         flush,
   // tags freed by retirement this cycle, 0 to 2
   input  logic [1:0]   retire_count,
   rename_slot_if.alloc slot1,
   rename_slot_if.alloc slot2,
   output logic         stall
);
   import rename_pkg::*;

   // index width, ROB_DEPTH must be a power of two up to 64
   localparam int PTR_BITS = $clog2(ROB_DEPTH);
   // free count needs one extra bit to hold ROB_DEPTH itself
   localparam int CNT_BITS = PTR_BITS + 1;

   ////////////////////////////////////////
   // allocator state
   ////////////////////////////////////////

   // next index to hand out
   logic [PTR_BITS-1:0] tail;
   // number of unused rob entries
   logic [CNT_BITS-1:0] free_count;

   // requests and grants of this cycle
   logic [1:0]          req_count;
   logic                grant_ok;
   logic                grant1;
   logic                grant2;
   logic [1:0]          grant_count;
   logic [PTR_BITS-1:0] idx1;
   logic [PTR_BITS-1:0] idx2;

   // rob index placed in the low field, ready and top bits clear
   function automatic tag_t make_tag(input logic [PTR_BITS-1:0] idx);
      logic [TAG_INDEX_BITS-1:0] wide;
      wide = TAG_INDEX_BITS'(idx);
      make_tag = {2'b00, wide};
   endfunction

   ////////////////////////////////////////
   // grant logic
   ////////////////////////////////////////

   assign req_count = {1'b0, slot1.valid} + {1'b0, slot2.valid};

   // stall when the requests exceed what is free
   assign stall = (CNT_BITS'(req_count) > free_count);

   // a stalled or flushing stage grants nothing
   assign grant_ok = !stall && !flush;
   assign grant1   = slot1.valid && grant_ok;
   assign grant2   = slot2.valid && grant_ok;

   assign grant_count = {1'b0, grant1} + {1'b0, grant2};

   // slot 2 takes the following index only when slot 1 used the tail
   assign idx1 = tail;
   assign idx2 = grant1 ? tail + PTR_BITS'(1) : tail;

   assign slot1.tag = grant1 ? make_tag(idx1) : TAG_NULL;
   assign slot2.tag = grant2 ? make_tag(idx2) : TAG_NULL;

   ////////////////////////////////////////
   // pointer and count update
   ////////////////////////////////////////

   always_ff @(posedge clock)
   begin
      // flush empties the rob just like reset, allocation restarts at 0
      if (reset || flush)
      begin
         tail       <= '0;
         free_count <= CNT_BITS'(ROB_DEPTH);
      end
      else
      begin
         // tail wraps naturally at the power-of-two depth
         tail       <= tail + PTR_BITS'(grant_count);
         // retired tags come back, granted tags leave
         free_count <= free_count + CNT_BITS'(retire_count)
                       - CNT_BITS'(grant_count);
      end
   end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build the rename stage testbench with Verilator, run it, and decide
# pass or fail from the simulation log
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module rename_tb -o rename_sim
if [ $? -ne 0 ]; then
   echo "verilator compile step returned an error"
   exit 1
fi

./obj_dir/rename_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^Test completed successfully$" "$LOG"; then
   exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* test/rename_sva.sv */
`timescale 1ns/1ns
// concurrent checks on the rename stage, bound into rename_unit
// covers the map table's zero register entry and the allocator's grants
module rename_sva (
   input logic             clock,
   input logic             reset,
   input logic             flush,
   input logic             stall,
   input rename_pkg::tag_t entry31,
   input rename_pkg::tag_t inst1_tag,
   input rename_pkg::tag_t inst2_tag,
   input rename_pkg::tag_t inst1_taga,
   input rename_pkg::tag_t inst1_tagb,
   input rename_pkg::tag_t inst2_taga,
   input rename_pkg::tag_t inst2_tagb
);
   import rename_pkg::*;

   // zero register never holds a producer
   a_zero_reg_null: assert property (@(posedge clock) disable iff (reset)
      entry31 == TAG_NULL)
      else $error("map table entry 31 holds %h", entry31);

   // a stalled stage hands out no tag at all
   a_stall_no_grant: assert property (@(posedge clock) disable iff (reset)
      stall |-> (inst1_tag == TAG_NULL) && (inst2_tag == TAG_NULL))
      else $error("tag granted while stalled");

   // table is empty one cycle after flush, only slot 1 forwarding can show
   a_flush_lookup: assert property (@(posedge clock) disable iff (reset)
      flush |=> (inst1_taga == TAG_NULL) && (inst1_tagb == TAG_NULL)
             && ((inst2_taga == TAG_NULL) || (inst2_taga == inst1_tag))
             && ((inst2_tagb == TAG_NULL) || (inst2_tagb == inst1_tag)))
      else $error("lookup not null after flush");

endmodule

bind rename_unit rename_sva u_rename_sva (
   .clock      (clock),
   .reset      (reset),
   .flush      (flush),
   .stall      (stall),
   .entry31    (u_map_table.tag_table[31]),
   .inst1_tag  (inst1_tag),
   .inst2_tag  (inst2_tag),
   .inst1_taga (inst1_taga),
   .inst1_tagb (inst1_tagb),
   .inst2_taga (inst2_taga),
   .inst2_tagb (inst2_tagb)
);

/* test/rename_tb.sv */
`timescale 1ns/1ns
// testbench for the two-wide rename stage
// a behavioral model of map table and allocator predicts every output
module rename_tb;
   import rename_pkg::*;

   localparam int ROB_DEPTH     = 16;
   localparam int STALL_TIMEOUT = 40;
   localparam int RANDOM_CYCLES = 400;

   logic       clock;
   logic       reset;
   logic       flush;
   logic [1:0] retire_count;
   tag_t       cdb1_tag;
   tag_t       cdb2_tag;
   logic       inst1_valid;
   reg_idx_t   inst1_rega;
   reg_idx_t   inst1_regb;
   reg_idx_t   inst1_dest;
   logic       inst2_valid;
   reg_idx_t   inst2_rega;
   reg_idx_t   inst2_regb;
   reg_idx_t   inst2_dest;
   logic       stall;
   tag_t       inst1_tag;
   tag_t       inst1_taga;
   tag_t       inst1_tagb;
   tag_t       inst2_tag;
   tag_t       inst2_taga;
   tag_t       inst2_tagb;

   ////////////////////////////////////////
   // reference model state
   ////////////////////////////////////////

   tag_t m_table [32];
   int   m_tail;
   int   m_free;
   // tags the model granted in the last checked cycle
   tag_t exp_tag1;
   tag_t exp_tag2;
   logic last_stall;

   int   errors;
   int   checks;
   int   tests_run;
   int   tests_failed;
   int   test_start_errors;

   rename_unit #(
      .ROB_DEPTH (ROB_DEPTH)
   ) u_rename_unit (
      .clock (clock), .reset (reset), .flush (flush), .retire_count (retire_count),
      .cdb1_tag (cdb1_tag), .cdb2_tag (cdb2_tag),
      .inst1_valid (inst1_valid), .inst1_rega (inst1_rega),
      .inst1_regb (inst1_regb), .inst1_dest (inst1_dest),
      .inst2_valid (inst2_valid), .inst2_rega (inst2_rega),
      .inst2_regb (inst2_regb), .inst2_dest (inst2_dest),
      .stall (stall),
      .inst1_tag (inst1_tag), .inst1_taga (inst1_taga), .inst1_tagb (inst1_tagb),
      .inst2_tag (inst2_tag), .inst2_taga (inst2_taga), .inst2_tagb (inst2_tagb)
   );

   initial
   begin
      clock = 1'b0;
      forever
      begin
         #10 clock = ~clock;
      end
   end

   task automatic check_value(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
      checks++;
      if (expected !== actual)
      begin
         $display("[FAIL] %s expected %h actual %h", name, expected, actual);
         errors++;
      end
   endtask

   ////////////////////////////////////////
   // model compare and next state
   ////////////////////////////////////////

   // called at the falling edge, compares this cycle, then steps the model
   task automatic compare_and_advance();
      int   req;
      int   granted;
      logic stall_exp;
      logic grant1;
      logic grant2;
      logic write1;
      logic write2;
      logic hit;
      tag_t next_table [32];

      req       = int'(inst1_valid) + int'(inst2_valid);
      stall_exp = req > m_free;
      grant1    = inst1_valid && !stall_exp && !flush;
      grant2    = inst2_valid && !stall_exp && !flush;
      exp_tag1  = grant1 ? {2'b00, 6'(m_tail)} : TAG_NULL;
      exp_tag2  = grant2 ? {2'b00, 6'(grant1 ? (m_tail + 1) % ROB_DEPTH : m_tail)}
                         : TAG_NULL;
      write1    = (inst1_dest != ZERO_REG) && (exp_tag1 != TAG_NULL);
      write2    = (inst2_dest != ZERO_REG) && (exp_tag2 != TAG_NULL);

      check_value("stall", {7'd0, stall_exp}, {7'd0, stall});
      check_value("inst1_tag", exp_tag1, inst1_tag);
      check_value("inst2_tag", exp_tag2, inst2_tag);
      check_value("inst1_taga", m_table[inst1_rega], inst1_taga);
      check_value("inst1_tagb", m_table[inst1_regb], inst1_tagb);
      // younger slot sees the older slot's new producer
      check_value("inst2_taga", (write1 && inst2_rega == inst1_dest) ? exp_tag1
                                : m_table[inst2_rega], inst2_taga);
      check_value("inst2_tagb", (write1 && inst2_regb == inst1_dest) ? exp_tag1
                                : m_table[inst2_regb], inst2_tagb);
      last_stall = stall;

      for (int i = 0; i < 32; i++)
      begin
         hit = ((cdb1_tag != TAG_NULL) && (cdb1_tag == m_table[i]))
            || ((cdb2_tag != TAG_NULL) && (cdb2_tag == m_table[i]));
         if (write2 && inst2_dest == 5'(i))
            next_table[i] = exp_tag2;
         else if (write1 && inst1_dest == 5'(i))
            next_table[i] = exp_tag1;
         else if (flush || m_table[i] == TAG_NULL)
            next_table[i] = TAG_NULL;
         else
            next_table[i] = {1'b0, m_table[i][6] | hit, m_table[i][5:0]};
      end
      next_table[31] = TAG_NULL;
      m_table = next_table;

      granted = int'(grant1) + int'(grant2);
      if (flush)
      begin
         m_tail = 0;
         m_free = ROB_DEPTH;
      end
      else
      begin
         m_tail = (m_tail + granted) % ROB_DEPTH;
         m_free = m_free + int'(retire_count) - granted;
      end
   endtask

   // one cycle of stimulus, retire count limited to tags in flight
   task automatic run_cycle(input logic v1, input reg_idx_t a1, b1, d1,
                            input logic v2, input reg_idx_t a2, b2, d2,
                            input logic fl, input int ret, input tag_t c1, c2);
      int safe_ret;
      safe_ret = (ret > ROB_DEPTH - m_free) ? ROB_DEPTH - m_free : ret;
      @(posedge clock);
      inst1_valid  <= v1;
      inst1_rega   <= a1;
      inst1_regb   <= b1;
      inst1_dest   <= d1;
      inst2_valid  <= v2;
      inst2_rega   <= a2;
      inst2_regb   <= b2;
      inst2_dest   <= d2;
      flush        <= fl;
      retire_count <= 2'(safe_ret);
      cdb1_tag     <= c1;
      cdb2_tag     <= c2;
      @(negedge clock);
      compare_and_advance();
   endtask

   // plain lookup of two registers on slot 1, nothing renamed
   task automatic lookup(input reg_idx_t ra, input reg_idx_t rb, input tag_t c1, c2);
      run_cycle(1'b0, ra, rb, 5'd0, 1'b0, ra, rb, 5'd0, 1'b0, 0, c1, c2);
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (errors == test_start_errors)
      begin
         $display("test %s: ok", name);
      end
      else
      begin
         tests_failed++;
         $display("test %s: %0d errors", name, errors - test_start_errors);
      end
      test_start_errors = errors;
   endtask

   // present the held request again until the stage accepts it
   task automatic wait_stall_clear(input logic v1, input reg_idx_t a1, b1, d1,
                                   input logic v2, input reg_idx_t a2, b2, d2);
      int count;
      count = 0;
      while (last_stall && count < STALL_TIMEOUT)
      begin
         run_cycle(v1, a1, b1, d1, v2, a2, b2, d2, 1'b0, 2, TAG_NULL, TAG_NULL);
         count++;
      end
      if (last_stall)
      begin
         $display("timeout: stall stayed high while tags were retired");
         errors++;
      end
   endtask

   ////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////

   initial
   begin
      logic     v1;
      logic     v2;
      reg_idx_t a1;
      reg_idx_t b1;
      reg_idx_t d1;
      reg_idx_t a2;
      reg_idx_t b2;
      reg_idx_t d2;
      tag_t     saved;
      tag_t     c1;

      void'($urandom(32'hfa6a_82e6));
      reset <= 1'b1;
      flush <= 1'b0;
      retire_count <= 2'd0;
      cdb1_tag <= TAG_NULL;
      cdb2_tag <= TAG_NULL;
      inst1_valid <= 1'b0;
      inst1_rega <= 5'd0;
      inst1_regb <= 5'd0;
      inst1_dest <= 5'd0;
      inst2_valid <= 1'b0;
      inst2_rega <= 5'd0;
      inst2_regb <= 5'd0;
      inst2_dest <= 5'd0;
      for (int i = 0; i < 32; i++)
         m_table[i] = TAG_NULL;
      m_tail = 0;
      m_free = ROB_DEPTH;
      last_stall = 1'b0;
      errors = 0;
      checks = 0;
      tests_run = 0;
      tests_failed = 0;
      test_start_errors = 0;

      // reset held for 8 cycles, lookups forced null meanwhile
      repeat (7) @(posedge clock);
      @(negedge clock);
      check_value("inst1_taga", TAG_NULL, inst1_taga);
      check_value("stall", 8'h00, {7'd0, stall});
      @(posedge clock);
      reset <= 1'b0;

      // behavior 1: empty table, then single renames read back
      for (int r = 0; r < 32; r++)
      begin
         lookup(5'(r), 5'(r), TAG_NULL, TAG_NULL);
         check_value("inst1_taga", TAG_NULL, inst1_taga);
      end
      for (int r = 0; r < 6; r++)
      begin
         run_cycle(1'b1, 5'd0, 5'd0, 5'(r), 1'b0, 5'd0, 5'd0, 5'd0, 1'b0, 0,
                   TAG_NULL, TAG_NULL);
         saved = exp_tag1;
         lookup(5'(r), 5'd31, TAG_NULL, TAG_NULL);
         check_value("inst1_taga", saved, inst1_taga);
      end
      end_test("reset_and_single_rename");

      // behavior 2: forwarding, blocked for the zero register
      run_cycle(1'b1, 5'd1, 5'd2, 5'd3, 1'b1, 5'd3, 5'd3, 5'd4, 1'b0, 1,
                TAG_NULL, TAG_NULL);
      run_cycle(1'b1, 5'd1, 5'd2, 5'd31, 1'b1, 5'd31, 5'd31, 5'd8, 1'b0, 2,
                TAG_NULL, TAG_NULL);
      check_value("inst2_taga", TAG_NULL, inst2_taga);
      end_test("same_cycle_forwarding");

      // behavior 3: double write, slot 2 wins
      run_cycle(1'b1, 5'd0, 5'd0, 5'd7, 1'b1, 5'd0, 5'd0, 5'd7, 1'b0, 2,
                TAG_NULL, TAG_NULL);
      saved = exp_tag2;
      lookup(5'd7, 5'd7, TAG_NULL, TAG_NULL);
      check_value("inst1_taga", saved, inst1_taga);
      end_test("double_write");

      // behavior 4: ready marking from each data bus port
      run_cycle(1'b1, 5'd0, 5'd0, 5'd5, 1'b1, 5'd0, 5'd0, 5'd6, 1'b0, 2,
                TAG_NULL, TAG_NULL);
      saved = exp_tag2;
      c1 = exp_tag1;
      lookup(5'd5, 5'd6, c1, TAG_NULL);
      check_value("inst1_taga", c1, inst1_taga);
      lookup(5'd5, 5'd6, TAG_NULL, saved);
      check_value("inst1_taga", c1 | 8'h40, inst1_taga);
      check_value("inst1_tagb", saved, inst1_tagb);
      lookup(5'd5, 5'd6, TAG_NULL, TAG_NULL);
      check_value("inst1_tagb", saved | 8'h40, inst1_tagb);
      end_test("data_bus_ready");

      // behavior 5: random traffic against the model
      for (int n = 0; n < RANDOM_CYCLES; n++)
      begin
         v1 = ($urandom % 4) != 0;
         v2 = ($urandom % 4) != 0;
         a1 = reg_idx_t'($urandom % 32);
         b1 = reg_idx_t'($urandom % 32);
         d1 = reg_idx_t'($urandom % 32);
         a2 = reg_idx_t'($urandom % 32);
         b2 = reg_idx_t'($urandom % 32);
         d2 = reg_idx_t'($urandom % 32);
         c1 = (($urandom % 2) != 0) ? m_table[5'($urandom % 32)] : TAG_NULL;
         // slow retirement so the free count runs out now and then
         run_cycle(v1, a1, b1, d1, v2, a2, b2, d2, ($urandom % 64) == 0,
                   (($urandom % 2) != 0) ? 0 : int'($urandom % 3),
                   c1, m_table[5'($urandom % 32)]);
         wait_stall_clear(v1, a1, b1, d1, v2, a2, b2, d2);
      end
      end_test("random_traffic");

      // behavior 6: flush empties table, allocation restarts at 0
      run_cycle(1'b1, 5'd0, 5'd0, 5'd9, 1'b1, 5'd0, 5'd0, 5'd10, 1'b0, 2,
                TAG_NULL, TAG_NULL);
      run_cycle(1'b1, 5'd9, 5'd10, 5'd11, 1'b1, 5'd0, 5'd0, 5'd12, 1'b1, 0,
                TAG_NULL, TAG_NULL);
      check_value("inst1_tag", TAG_NULL, inst1_tag);
      for (int r = 0; r < 32; r++)
      begin
         lookup(5'(r), 5'(r), TAG_NULL, TAG_NULL);
         check_value("inst1_taga", TAG_NULL, inst1_taga);
      end
      run_cycle(1'b1, 5'd0, 5'd0, 5'd1, 1'b1, 5'd0, 5'd0, 5'd2, 1'b0, 0,
                TAG_NULL, TAG_NULL);
      check_value("inst1_tag", 8'h00, inst1_tag);
      check_value("inst2_tag", 8'h01, inst2_tag);
      // whole rob free again, pairs run without stall until ROB_DEPTH tags are out
      for (int n = 1; n < ROB_DEPTH / 2; n++)
      begin
         run_cycle(1'b1, 5'd0, 5'd0, 5'(n), 1'b1, 5'd0, 5'd0, 5'(n + 8), 1'b0, 0,
                   TAG_NULL, TAG_NULL);
         check_value("stall", 8'h00, {7'd0, stall});
      end
      run_cycle(1'b1, 5'd0, 5'd0, 5'd1, 1'b1, 5'd0, 5'd0, 5'd2, 1'b0, 0,
                TAG_NULL, TAG_NULL);
      check_value("stall", 8'h01, {7'd0, stall});
      end_test("flush");

      $display("tests run %0d, tests with errors %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0)
      begin
         $display("Test completed successfully");
      end
      else
      begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* verilog.f */
logic/rename_pkg.sv
logic/rename_slot_if.sv
logic/tag_alloc.sv
logic/map_table.sv
logic/rename_unit.sv
test/rename_sva.sv
test/rename_tb.sv
